// File: common/periph_cfg_pkg.sv
// Peripheral subsystem configuration
// Bus, GPIO and timer widths and the word types built on them
`default_nettype none

package periph_cfg_pkg;

   // ********************
   // Bus
   localparam int DATA_W = 32;
   localparam int ADDR_W = 12;

   // ********************
   // Peripherals
   localparam int GPIO_W      = 32;
   localparam int SYNC_STAGES = 2;
   localparam int PRESCALE_W  = 16;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [GPIO_W-1:0] gpio_t;

   // Word index inside a block from address bits 5:2
   typedef logic [3:0] reg_idx_t;

endpackage

`default_nettype wire

// File: common/periph_map_pkg.sv
// Peripheral subsystem address map
// Block select field, block numbers and per-block register offsets
`default_nettype none

package periph_map_pkg;

   // ********************
   // Block decode
   localparam int BLK_SEL_HI = 11;
   localparam int BLK_SEL_LO = 8;
   localparam int REG_IDX_LO = 2;

   localparam logic [BLK_SEL_HI-BLK_SEL_LO:0] BLK_GPIO  = 'd0;
   localparam logic [BLK_SEL_HI-BLK_SEL_LO:0] BLK_TIMER = 'd1;

   // ********************
   // GPIO registers
   localparam logic [3:0] GPIO_OUT      = 4'd0;
   localparam logic [3:0] GPIO_OE       = 4'd1;
   localparam logic [3:0] GPIO_IN       = 4'd2;
   localparam logic [3:0] GPIO_IRQ_EN   = 4'd3;
   localparam logic [3:0] GPIO_IRQ_STAT = 4'd4;

   // ********************
   // Timer registers
   localparam logic [3:0] TMR_CTRL     = 4'd0;
   localparam logic [3:0] TMR_PRESCALE = 4'd1;
   localparam logic [3:0] TMR_COUNT    = 4'd2;
   localparam logic [3:0] TMR_COMPARE  = 4'd3;

   localparam int TMR_CTRL_RUN    = 0;
   localparam int TMR_CTRL_IRQ_EN = 1;

endpackage

`default_nettype wire

// File: compile.f
common/periph_cfg_pkg.sv
common/periph_map_pkg.sv
hw/apb_fabric.sv
hw/gpio/gpio_regs.sv
hw/timer/timer_core.sv
hw/periph_top.sv
tests/tb_periph_top.sv

// File: hw/apb_fabric.sv
// APB3 fabric for the peripheral subsystem
// Decodes the block number, raises one block select and returns the
// selected block's read word in the access cycle. Unmapped blocks get
// a slave error with zero data. No wait states.
`default_nettype none

module apb_fabric (
   input  wire                            clk,
   input  wire                            i_rst,
   input  wire                            i_psel,
   input  wire                            i_penable,
   input  wire                            i_pwrite,
   input  wire periph_cfg_pkg::addr_t     i_paddr,
   input  wire periph_cfg_pkg::data_t     i_pwdata,
   input  wire periph_cfg_pkg::data_t     i_gpio_rdata,
   input  wire periph_cfg_pkg::data_t     i_tmr_rdata,
   output logic                           o_gpio_sel,
   output logic                           o_tmr_sel,
   output logic                           o_access,
   output logic                           o_write,
   output periph_cfg_pkg::reg_idx_t       o_reg_idx,
   output periph_cfg_pkg::data_t          o_wdata,
   output periph_cfg_pkg::data_t          o_prdata,
   output logic                           o_pready,
   output logic                           o_pslverr
);
   import periph_cfg_pkg::*;
   import periph_map_pkg::*;

   logic [BLK_SEL_HI:BLK_SEL_LO] blk_num;
   logic                         gpio_hit;
   logic                         tmr_hit;
   logic                         setup;
   logic                         access_ph;
   logic                         gpio_hit_q;
   logic                         tmr_hit_q;

   assign blk_num   = i_paddr[BLK_SEL_HI:BLK_SEL_LO];
   assign gpio_hit  = (blk_num == BLK_GPIO);
   assign tmr_hit   = (blk_num == BLK_TIMER);
   assign setup     = i_psel & ~i_penable;
   assign access_ph = i_psel & i_penable;

   // Shared block-side signals
   assign o_gpio_sel = i_psel & gpio_hit;
   assign o_tmr_sel  = i_psel & tmr_hit;
   assign o_access   = access_ph;
   assign o_write    = i_pwrite;
   assign o_reg_idx  = i_paddr[REG_IDX_LO +: $bits(reg_idx_t)];
   assign o_wdata    = i_pwdata;

   // Target block captured at the end of setup
   always_ff @(posedge clk) begin
      if (i_rst) begin
         gpio_hit_q <= 1'b0;
         tmr_hit_q  <= 1'b0;
      end else if (setup) begin
         gpio_hit_q <= gpio_hit;
         tmr_hit_q  <= tmr_hit;
      end
   end

   // ********************
   // Access cycle response
   assign o_pready  = access_ph;
   assign o_pslverr = access_ph & ~(gpio_hit_q | tmr_hit_q);

   always_comb begin
      o_prdata = '0;
      if (access_ph && gpio_hit_q) begin
         o_prdata = i_gpio_rdata;
      end else if (access_ph && tmr_hit_q) begin
         o_prdata = i_tmr_rdata;
      end
   end

endmodule

`default_nettype wire

// File: hw/gpio/gpio_regs.sv
// GPIO register block
// Output and output-enable registers, a synchronised input, and a
// rising-edge interrupt with per-pin enable and write-one-to-clear status.
// The read word is captured at the end of the setup cycle.
`default_nettype none

module gpio_regs (
   input  wire                            clk,
   input  wire                            i_rst,
   input  wire                            i_sel,
   input  wire                            i_access,
   input  wire                            i_write,
   input  wire periph_cfg_pkg::reg_idx_t  i_reg_idx,
   input  wire periph_cfg_pkg::data_t     i_wdata,
   input  wire periph_cfg_pkg::gpio_t     i_gpio_in,
   output periph_cfg_pkg::data_t          o_rdata,
   output periph_cfg_pkg::gpio_t          o_gpio_out,
   output periph_cfg_pkg::gpio_t          o_gpio_oe,
   output logic                           o_gpio_irq
);
   import periph_cfg_pkg::*;
   import periph_map_pkg::*;

   gpio_t                   out_q;
   gpio_t                   oe_q;
   gpio_t                   irq_en_q;
   gpio_t                   irq_stat_q;
   gpio_t [SYNC_STAGES-1:0] sync_q;
   gpio_t                   pin_sync;
   gpio_t                   pin_prev_q;
   gpio_t                   rise;
   gpio_t                   stat_clr;
   logic                    irq_q;
   logic                    wr_en;
   logic                    rd_sample;
   data_t                   rd_word;

   assign wr_en     = i_sel & i_access & i_write;
   assign rd_sample = i_sel & ~i_access;

   // ********************
   // Software registers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         out_q    <= '0;
         oe_q     <= '0;
         irq_en_q <= '0;
      end else if (wr_en) begin
         case (i_reg_idx)
            GPIO_OUT:    out_q    <= i_wdata[GPIO_W-1:0];
            GPIO_OE:     oe_q     <= i_wdata[GPIO_W-1:0];
            GPIO_IRQ_EN: irq_en_q <= i_wdata[GPIO_W-1:0];
            default: ;
         endcase
      end
   end

   // ********************
   // Input path
   always_ff @(posedge clk) begin
      if (i_rst) begin
         sync_q     <= '0;
         pin_prev_q <= '0;
      end else begin
         sync_q[0] <= i_gpio_in;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         pin_prev_q <= pin_sync;
      end
   end

   assign pin_sync = sync_q[SYNC_STAGES-1];
   assign rise     = pin_sync & ~pin_prev_q;

   // A new edge wins over a clear in the same cycle
   assign stat_clr = (wr_en && i_reg_idx == GPIO_IRQ_STAT) ? i_wdata[GPIO_W-1:0] : '0;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         irq_stat_q <= '0;
         irq_q      <= 1'b0;
      end else begin
         irq_stat_q <= (irq_stat_q & ~stat_clr) | (rise & irq_en_q);
         irq_q      <= |irq_stat_q;
      end
   end

   // ********************
   // Read back
   always_comb begin
      rd_word = '0;
      case (i_reg_idx)
         GPIO_OUT:      rd_word[GPIO_W-1:0] = out_q;
         GPIO_OE:       rd_word[GPIO_W-1:0] = oe_q;
         GPIO_IN:       rd_word[GPIO_W-1:0] = pin_sync;
         GPIO_IRQ_EN:   rd_word[GPIO_W-1:0] = irq_en_q;
         GPIO_IRQ_STAT: rd_word[GPIO_W-1:0] = irq_stat_q;
         default:       rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_rdata <= '0;
      end else if (rd_sample) begin
         o_rdata <= rd_word;
      end
   end

   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = irq_q;

endmodule

`default_nettype wire

// File: hw/periph_top.sv
// Peripheral subsystem top level
// One APB3 slave port in front of a GPIO block and a system timer.
// Pads are built outside from the output value and output enable ports.
`default_nettype none

module periph_top (
   input  wire                          clk,
   input  wire                          i_rst,
   input  wire                          i_psel,
   input  wire                          i_penable,
   input  wire                          i_pwrite,
   input  wire periph_cfg_pkg::addr_t   i_paddr,
   input  wire periph_cfg_pkg::data_t   i_pwdata,
   output periph_cfg_pkg::data_t        o_prdata,
   output logic                         o_pready,
   output logic                         o_pslverr,
   input  wire periph_cfg_pkg::gpio_t   i_gpio_in,
   output periph_cfg_pkg::gpio_t        o_gpio_out,
   output periph_cfg_pkg::gpio_t        o_gpio_oe,
   output logic                         o_gpio_irq,
   output logic                         o_timer_irq
);
   import periph_cfg_pkg::*;

   // Fabric to block signals
   logic     gpio_sel;
   logic     tmr_sel;
   logic     access;
   logic     write;
   reg_idx_t reg_idx;
   data_t    wdata;
   data_t    gpio_rdata;
   data_t    tmr_rdata;

   apb_fabric u_fabric (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .i_gpio_rdata (gpio_rdata),
      .i_tmr_rdata  (tmr_rdata),
      .o_gpio_sel   (gpio_sel),
      .o_tmr_sel    (tmr_sel),
      .o_access     (access),
      .o_write      (write),
      .o_reg_idx    (reg_idx),
      .o_wdata      (wdata),
      .o_prdata     (o_prdata),
      .o_pready     (o_pready),
      .o_pslverr    (o_pslverr)
   );

   gpio_regs u_gpio (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_sel      (gpio_sel),
      .i_access   (access),
      .i_write    (write),
      .i_reg_idx  (reg_idx),
      .i_wdata    (wdata),
      .i_gpio_in  (i_gpio_in),
      .o_rdata    (gpio_rdata),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq)
   );

   timer_core u_timer (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_sel       (tmr_sel),
      .i_access    (access),
      .i_write     (write),
      .i_reg_idx   (reg_idx),
      .i_wdata     (wdata),
      .o_rdata     (tmr_rdata),
      .o_timer_irq (o_timer_irq)
   );

endmodule

`default_nettype wire

// File: hw/timer/timer_core.sv
// System timer
// Free-running counter behind a programmable prescaler, with a compare
// register and a level interrupt held while count >= compare.
// The read word is captured at the end of the setup cycle.
`default_nettype none

module timer_core (
   input  wire                            clk,
   input  wire                            i_rst,
   input  wire                            i_sel,
   input  wire                            i_access,
   input  wire                            i_write,
   input  wire periph_cfg_pkg::reg_idx_t  i_reg_idx,
   input  wire periph_cfg_pkg::data_t     i_wdata,
   output periph_cfg_pkg::data_t          o_rdata,
   output logic                           o_timer_irq
);
   import periph_cfg_pkg::*;
   import periph_map_pkg::*;

   logic                  run_q;
   logic                  irq_en_q;
   logic [PRESCALE_W-1:0] prescale_q;
   logic [PRESCALE_W-1:0] div_q;
   data_t                 count_q;
   data_t                 compare_q;
   logic                  tick;
   logic                  irq_q;
   logic                  wr_en;
   logic                  rd_sample;
   data_t                 rd_word;

   assign wr_en     = i_sel & i_access & i_write;
   assign rd_sample = i_sel & ~i_access;

   // ********************
   // Control registers
   always_ff @(posedge clk) begin
      if (i_rst) begin
         run_q      <= 1'b0;
         irq_en_q   <= 1'b0;
         prescale_q <= '0;
         compare_q  <= '0;
      end else if (wr_en) begin
         case (i_reg_idx)
            TMR_CTRL: begin
               run_q    <= i_wdata[TMR_CTRL_RUN];
               irq_en_q <= i_wdata[TMR_CTRL_IRQ_EN];
            end
            TMR_PRESCALE: prescale_q <= i_wdata[PRESCALE_W-1:0];
            TMR_COMPARE:  compare_q  <= i_wdata;
            default: ;
         endcase
      end
   end

   // ********************
   // Prescaler and counter
   // >= keeps the divider sane if prescale shrinks below the current value
   assign tick = run_q && (div_q >= prescale_q);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         div_q   <= '0;
         count_q <= '0;
      end else begin
         if (!run_q || tick) begin
            div_q <= '0;
         end else begin
            div_q <= div_q + 1'b1;
         end

         // Software write beats the increment
         if (wr_en && i_reg_idx == TMR_COUNT) begin
            count_q <= i_wdata;
         end else if (tick) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         irq_q <= 1'b0;
      end else begin
         irq_q <= irq_en_q && (count_q >= compare_q);
      end
   end

   // ********************
   // Read back
   always_comb begin
      rd_word = '0;
      case (i_reg_idx)
         TMR_CTRL: begin
            rd_word[TMR_CTRL_RUN]    = run_q;
            rd_word[TMR_CTRL_IRQ_EN] = irq_en_q;
         end
         TMR_PRESCALE: rd_word[PRESCALE_W-1:0] = prescale_q;
         TMR_COUNT:    rd_word = count_q;
         TMR_COMPARE:  rd_word = compare_q;
         default:      rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_rdata <= '0;
      end else if (rd_sample) begin
         o_rdata <= rd_word;
      end
   end

   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_periph_top -f compile.f -o tb_periph_top > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_periph_top > sim.log 2>&1 ; cat sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

// File: tests/tb_periph_top.sv
// Testbench for the peripheral subsystem
// Applies a table of APB accesses, pin changes and interrupt waits to the
// DUT, then checks the timer prescaler and stop with directed reads.
`default_nettype none

module tb_periph_top;
   timeunit 1ns;
   timeprecision 100ps;

   import periph_cfg_pkg::*;
   import periph_map_pkg::*;

   localparam int TIMEOUT = 100;

   // ********************
   // Table operations
   localparam logic [2:0] OP_WR        = 3'd0;
   localparam logic [2:0] OP_RD        = 3'd1;
   localparam logic [2:0] OP_PINS      = 3'd2;
   localparam logic [2:0] OP_CHK_OUT   = 3'd3;
   localparam logic [2:0] OP_CHK_OE    = 3'd4;
   localparam logic [2:0] OP_WAIT_GIRQ = 3'd5;
   localparam logic [2:0] OP_WAIT_TIRQ = 3'd6;
   localparam logic [2:0] OP_RD_GE     = 3'd7;

   localparam data_t OUT_VAL  = 32'ha5a5_0f0f;
   localparam data_t OE_VAL   = 32'hffff_00ff;
   localparam data_t PIN_VAL  = 32'h1234_5678;
   localparam data_t PIN_PAT  = 32'h0f0f_00f3;
   localparam data_t IRQ_MASK = 32'h0000_ff0f;

   typedef struct packed {
      logic [2:0] op;
      logic [3:0] blk;
      logic [3:0] idx;
      data_t      data;
      data_t      exp;
      logic       exp_err;
   } row_t;

   logic  clk;
   logic  rst;
   logic  psel;
   logic  penable;
   logic  pwrite;
   addr_t paddr;
   data_t pwdata;
   gpio_t gpio_in;
   data_t prdata;
   logic  pready;
   logic  pslverr;
   gpio_t gpio_out;
   gpio_t gpio_oe;
   logic  gpio_irq;
   logic  timer_irq;

   int   errors = 0;
   int   cycle = 0;
   row_t rows[$];

   periph_top u_dut (
      .clk         (clk),
      .i_rst       (rst),
      .i_psel      (psel),
      .i_penable   (penable),
      .i_pwrite    (pwrite),
      .i_paddr     (paddr),
      .i_pwdata    (pwdata),
      .o_prdata    (prdata),
      .o_pready    (pready),
      .o_pslverr   (pslverr),
      .i_gpio_in   (gpio_in),
      .o_gpio_out  (gpio_out),
      .o_gpio_oe   (gpio_oe),
      .o_gpio_irq  (gpio_irq),
      .o_timer_irq (timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   function automatic addr_t reg_addr(input logic [3:0] blk, input logic [3:0] idx);
      addr_t a;
      a = '0;
      a[BLK_SEL_HI:BLK_SEL_LO] = blk;
      a[REG_IDX_LO +: 4] = idx;
      return a;
   endfunction

   task automatic compare_word(input string name, input data_t exp, input data_t act);
      assert (act === exp) else begin
         $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_min(input string name, input data_t exp, input data_t act);
      assert (act >= exp) else begin
         $display("Mismatch at %0d ns: %s expected >= %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // Sampled mid-cycle, once the access cycle outputs have settled
   task automatic wait_ready();
      int waited;
      waited = 0;
      @(negedge clk);
      while (!pready && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (pready) else begin
         $display("Error at %0d ns: o_pready never rose in the access cycle", $time);
         errors++;
      end
   endtask

   task automatic write_reg(input addr_t addr, input data_t data, output logic err);
      @(posedge clk);
      #1;
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      wait_ready();
      err = pslverr;
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic read_reg(input addr_t addr, output data_t data, output logic err);
      @(posedge clk);
      #1;
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      wait_ready();
      data = prdata;
      err = pslverr;
      @(posedge clk);
      #1;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   // Fixed gap covers the two-stage synchroniser
   task automatic drive_pins(input gpio_t val);
      @(posedge clk);
      #1;
      gpio_in = val;
      repeat (4) @(posedge clk);
   endtask

   task automatic wait_irq(input logic use_timer, input logic level);
      int    waited;
      logic  val;
      string name;
      waited = 0;
      name = use_timer ? "o_timer_irq" : "o_gpio_irq";
      @(negedge clk);
      val = use_timer ? timer_irq : gpio_irq;
      while (val !== level && waited < TIMEOUT) begin
         @(negedge clk);
         val = use_timer ? timer_irq : gpio_irq;
         waited++;
      end
      assert (val === level) else begin
         $display("Error at %0d ns: %s did not go to %0b within %0d cycles",
                  $time, name, level, TIMEOUT);
         errors++;
      end
   endtask

   task automatic add_row(input logic [2:0] op, input logic [3:0] blk, input logic [3:0] idx,
                          input data_t data, input data_t exp, input logic exp_err);
      row_t r;
      r.op = op;
      r.blk = blk;
      r.idx = idx;
      r.data = data;
      r.exp = exp;
      r.exp_err = exp_err;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // Output registers
      add_row(OP_WR,      BLK_GPIO, GPIO_OUT, OUT_VAL, '0, 1'b0);
      add_row(OP_CHK_OUT, BLK_GPIO, GPIO_OUT, '0, OUT_VAL, 1'b0);
      add_row(OP_WR,      BLK_GPIO, GPIO_OE, OE_VAL, '0, 1'b0);
      add_row(OP_CHK_OE,  BLK_GPIO, GPIO_OE, '0, OE_VAL, 1'b0);
      add_row(OP_RD,      BLK_GPIO, GPIO_OUT, '0, OUT_VAL, 1'b0);
      add_row(OP_RD,      BLK_GPIO, GPIO_OE, '0, OE_VAL, 1'b0);
      // GPIO_IN follows the pins and ignores writes
      add_row(OP_PINS,    BLK_GPIO, GPIO_IN, PIN_VAL, '0, 1'b0);
      add_row(OP_RD,      BLK_GPIO, GPIO_IN, '0, PIN_VAL, 1'b0);
      add_row(OP_WR,      BLK_GPIO, GPIO_IN, 32'hffff_ffff, '0, 1'b0);
      add_row(OP_RD,      BLK_GPIO, GPIO_IN, '0, PIN_VAL, 1'b0);
      add_row(OP_PINS,    BLK_GPIO, GPIO_IN, '0, '0, 1'b0);
      add_row(OP_RD,      BLK_GPIO, GPIO_IN, '0, '0, 1'b0);
      // Edge interrupt
      add_row(OP_WR,        BLK_GPIO, GPIO_IRQ_EN, IRQ_MASK, '0, 1'b0);
      add_row(OP_PINS,      BLK_GPIO, GPIO_IN, PIN_PAT, '0, 1'b0);
      add_row(OP_WAIT_GIRQ, BLK_GPIO, GPIO_IN, 32'd1, '0, 1'b0);
      add_row(OP_RD,        BLK_GPIO, GPIO_IRQ_STAT, '0, PIN_PAT & IRQ_MASK, 1'b0);
      add_row(OP_WR,        BLK_GPIO, GPIO_IRQ_STAT, PIN_PAT & IRQ_MASK, '0, 1'b0);
      add_row(OP_WAIT_GIRQ, BLK_GPIO, GPIO_IN, 32'd0, '0, 1'b0);
      add_row(OP_RD,        BLK_GPIO, GPIO_IRQ_STAT, '0, '0, 1'b0);
      // Timer compare
      add_row(OP_WR,        BLK_TIMER, TMR_PRESCALE, 32'd0, '0, 1'b0);
      add_row(OP_WR,        BLK_TIMER, TMR_COUNT, 32'd0, '0, 1'b0);
      add_row(OP_WR,        BLK_TIMER, TMR_COMPARE, 32'd20, '0, 1'b0);
      add_row(OP_WR,        BLK_TIMER, TMR_CTRL, 32'd3, '0, 1'b0);
      add_row(OP_WAIT_TIRQ, BLK_TIMER, TMR_CTRL, 32'd1, '0, 1'b0);
      add_row(OP_RD_GE,     BLK_TIMER, TMR_COUNT, '0, 32'd20, 1'b0);
      add_row(OP_WR,        BLK_TIMER, TMR_COMPARE, 32'h0010_0000, '0, 1'b0);
      add_row(OP_WAIT_TIRQ, BLK_TIMER, TMR_CTRL, 32'd0, '0, 1'b0);
      // Unmapped blocks and unknown register index
      add_row(OP_WR, 4'd2,     GPIO_OUT, 32'hffff_ffff, '0, 1'b1);
      add_row(OP_RD, 4'd2,     GPIO_OUT, '0, '0, 1'b1);
      add_row(OP_RD, 4'd15,    GPIO_OUT, '0, '0, 1'b1);
      add_row(OP_RD, BLK_GPIO, GPIO_OUT, '0, OUT_VAL, 1'b0);
      add_row(OP_WR, BLK_GPIO, 4'd9, 32'h0000_1234, '0, 1'b0);
      add_row(OP_RD, BLK_GPIO, 4'd9, '0, '0, 1'b0);
      add_row(OP_RD, BLK_GPIO, GPIO_OUT, '0, OUT_VAL, 1'b0);
   endtask

   task automatic run_row(input row_t r);
      data_t rdata;
      logic  err;
      case (r.op)
         OP_WR: begin
            write_reg(reg_addr(r.blk, r.idx), r.data, err);
            compare_word("o_pslverr", data_t'(r.exp_err), data_t'(err));
         end
         OP_RD, OP_RD_GE: begin
            read_reg(reg_addr(r.blk, r.idx), rdata, err);
            compare_word("o_pslverr", data_t'(r.exp_err), data_t'(err));
            if (r.op == OP_RD_GE) begin
               check_min("o_prdata", r.exp, rdata);
            end else begin
               compare_word("o_prdata", r.exp, rdata);
            end
         end
         OP_PINS:      drive_pins(r.data);
         OP_CHK_OUT:   compare_word("o_gpio_out", r.exp, gpio_out);
         OP_CHK_OE:    compare_word("o_gpio_oe", r.exp, gpio_oe);
         OP_WAIT_GIRQ: wait_irq(1'b0, r.data[0]);
         OP_WAIT_TIRQ: wait_irq(1'b1, r.data[0]);
         default: ;
      endcase
   endtask

   // ********************
   // Main sequence
   initial begin
      data_t c1;
      data_t c2;
      logic  err;
      int    t1;
      int    t2;
      int    diff;
      int    lo;
      int    hi;

      rst = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      gpio_in = '0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      @(negedge clk);
      compare_word("o_gpio_out", '0, gpio_out);
      compare_word("o_gpio_oe", '0, gpio_oe);
      compare_word("o_gpio_irq", '0, data_t'(gpio_irq));
      compare_word("o_timer_irq", '0, data_t'(timer_irq));
      compare_word("o_pready", '0, data_t'(pready));
      compare_word("o_pslverr", '0, data_t'(pslverr));
      compare_word("o_prdata", '0, prdata);

      build_table();
      for (int i = 0; i < rows.size(); i++) begin
         run_row(rows[i]);
      end

      // Stopped timer holds its count
      write_reg(reg_addr(BLK_TIMER, TMR_CTRL), 32'd0, err);
      compare_word("o_pslverr", '0, data_t'(err));
      read_reg(reg_addr(BLK_TIMER, TMR_COUNT), c1, err);
      compare_word("o_pslverr", '0, data_t'(err));
      repeat (10) @(posedge clk);
      read_reg(reg_addr(BLK_TIMER, TMR_COUNT), c2, err);
      compare_word("o_pslverr", '0, data_t'(err));
      compare_word("COUNT", c1, c2);

      // Divide by four
      write_reg(reg_addr(BLK_TIMER, TMR_PRESCALE), 32'd3, err);
      compare_word("o_pslverr", '0, data_t'(err));
      write_reg(reg_addr(BLK_TIMER, TMR_CTRL), data_t'(1) << TMR_CTRL_RUN, err);
      compare_word("o_pslverr", '0, data_t'(err));
      read_reg(reg_addr(BLK_TIMER, TMR_COUNT), c1, err);
      compare_word("o_pslverr", '0, data_t'(err));
      t1 = cycle;
      repeat (40) @(posedge clk);
      read_reg(reg_addr(BLK_TIMER, TMR_COUNT), c2, err);
      compare_word("o_pslverr", '0, data_t'(err));
      t2 = cycle;
      diff = int'(c2 - c1);
      lo = (t2 - t1) / 4 - 1;
      hi = (t2 - t1) / 4 + 1;
      assert (diff >= lo && diff <= hi) else begin
         $display("Mismatch at %0d ns: COUNT step expected %0d to %0d, got %0d",
                  $time, lo, hi, diff);
         errors++;
      end

      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
